//--- common/msx_io_pkg.sv
package msx_io_pkg;

	// ------------------------------------------------------------------------
	// bus widths
	// ------------------------------------------------------------------------

	// full 16-bit bus address
	typedef logic [15:0] io_addr_t;
	// one data byte on the bus
	typedef logic [7:0]  bus_data_t;

	// ------------------------------------------------------------------------
	// keyboard and slot widths
	// ------------------------------------------------------------------------

	// keyboard row number, 0 to 15
	typedef logic [3:0]  key_row_t;
	// column bit inside one row
	typedef logic [2:0]  key_col_t;
	// primary slot register, four 2-bit fields, page 0 in bits 1:0
	typedef logic [7:0]  slot_reg_t;
	// one-hot slot chip select
	typedef logic [3:0]  slot_cs_t;

	// port C layout, top bit first
	typedef struct packed {
		logic     click_sound;
		logic     caps_led_off;
		logic     cas_write;
		logic     motor_off;
		key_row_t key_row;
	} port_c_t;

	// one key event from the keyboard controller
	typedef struct packed {
		// 1 = press, 0 = release
		logic     pressed;
		key_row_t row;
		key_col_t column;
	} key_event_t;

	// ------------------------------------------------------------------------
	// port map
	// ------------------------------------------------------------------------

	// A8h..ABh share address bits 7:2
	localparam logic [5:0] PPI_PORT_BASE = 6'b1010_10;

	// offsets inside the group
	localparam logic [1:0] PORT_A    = 2'd0;
	localparam logic [1:0] PORT_B    = 2'd1;
	localparam logic [1:0] PORT_C    = 2'd2;
	localparam logic [1:0] PORT_MODE = 2'd3;

	// rows 0..10 exist, the rest read FFh
	localparam int KEY_ROWS = 11;

	// row 15, motor off, cas write high, caps led off, click low
	localparam port_c_t   PORT_C_RESET = 8'h7F;
	// all pages on slot 0
	localparam slot_reg_t SLOT_RESET   = 8'h00;

endpackage

//--- ppi/msx_ppi.sv
module msx_ppi
	import msx_io_pkg::*;
(
	input  logic      clk,
	input  logic      n_reset,
	// bus side
	input  io_addr_t  address,
	input  bus_data_t write_data,
	input  logic      read,
	input  logic      write,
	input  logic      io,
	output logic      read_ready,
	output bus_data_t read_data,
	// keyboard matrix column for the current row, active low
	input  bus_data_t key_column,
	// register outputs
	output slot_reg_t primary_slot,
	output port_c_t   port_c
);

	logic      w_ppi_dec;
	logic      w_io_write;
	logic      w_io_read;
	slot_reg_t ff_primary_slot;
	port_c_t   ff_port_c;
	logic      ff_read_ready;
	logic [1:0] ff_read_port;
	bus_data_t w_read;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------

	// only the low byte counts, the upper byte of an I/O address is don't care
	assign w_ppi_dec  = (address[7:2] == PPI_PORT_BASE);
	assign w_io_write = io && write && w_ppi_dec;
	assign w_io_read  = io && read && w_ppi_dec;

	// ------------------------------------------------------------------------
	// port A and port C registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_primary_slot <= SLOT_RESET;
			ff_port_c       <= PORT_C_RESET;
		end else if (w_io_write) begin
			case (address[1:0])
				PORT_A: begin
					ff_primary_slot <= write_data;
				end
				PORT_C: begin
					ff_port_c <= port_c_t'(write_data);
				end
				default: begin
					// port B is input only, mode port writes are dropped
				end
			endcase
		end
	end

	assign primary_slot = ff_primary_slot;
	assign port_c       = ff_port_c;

	// ------------------------------------------------------------------------
	// read response
	// ------------------------------------------------------------------------

	// ready follows the held read one cycle late, mode port stays silent
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_ready <= 1'b0;
		end else begin
			ff_read_ready <= w_io_read && (address[1:0] != PORT_MODE);
		end
	end

	// offset of the read in flight, taken each cycle the read is seen
	always_ff @(posedge clk) begin
		if (w_io_read) begin
			ff_read_port <= address[1:0];
		end
	end

	always_comb begin
		case (ff_read_port)
			PORT_A:  w_read = ff_primary_slot;
			PORT_B:  w_read = key_column;
			PORT_C:  w_read = ff_port_c;
			default: w_read = '0;
		endcase
	end

	// bus stays quiet outside the ready window
	assign read_data  = ff_read_ready ? w_read : '0;
	assign read_ready = ff_read_ready;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// no data leaks onto the bus without ready
	a_quiet_bus: assert property (@(posedge clk) disable iff (!n_reset)
		!read_ready |-> (read_data == '0));

endmodule

//--- keyboard/key_matrix.sv
module key_matrix
	import msx_io_pkg::*;
(
	input  logic       clk,
	input  logic       n_reset,
	// key events, four-phase req/ack
	input  logic       key_req,
	input  key_event_t key_event,
	output logic       key_ack,
	// row select from port C and the column byte back
	input  key_row_t   key_row,
	output bus_data_t  key_column
);

	// one active-low byte per implemented row
	bus_data_t ff_matrix [KEY_ROWS];
	logic      ff_ack;
	logic      w_accept;
	bus_data_t w_column;

	// ------------------------------------------------------------------------
	// handshake
	// ------------------------------------------------------------------------

	// a new event is taken only while ack is low
	assign w_accept = key_req && !ff_ack;

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_ack <= 1'b0;
		end else if (w_accept) begin
			// event applied at this same edge
			ff_ack <= 1'b1;
		end else if (!key_req) begin
			// controller has let go, finish the cycle
			ff_ack <= 1'b0;
		end
	end

	assign key_ack = ff_ack;

	// ------------------------------------------------------------------------
	// matrix store
	// ------------------------------------------------------------------------

	// reset means no key pressed anywhere
	// an event for row 11..15 matches no entry and is simply dropped
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < KEY_ROWS; i++) begin
				ff_matrix[i] <= '1;
			end
		end else if (w_accept) begin
			for (int i = 0; i < KEY_ROWS; i++) begin
				if (key_event.row == key_row_t'(i)) begin
					// pressed pulls the bit low
					ff_matrix[i][key_event.column] <= !key_event.pressed;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// column readout
	// ------------------------------------------------------------------------

	// rows past the last one float high, like an open matrix line
	always_comb begin
		w_column = '1;
		for (int i = 0; i < KEY_ROWS; i++) begin
			if (key_row == key_row_t'(i)) begin
				w_column = ff_matrix[i];
			end
		end
	end

	assign key_column = w_column;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// controller keeps the event still for the whole request
	a_event_stable: assert property (@(posedge clk) disable iff (!n_reset)
		(key_req && $past(key_req)) |-> $stable(key_event));

endmodule

//--- src/slot_select.sv
module slot_select
	import msx_io_pkg::*;
(
	input  logic      clk,
	input  logic      n_reset,
	// memory side of the bus
	input  io_addr_t  address,
	input  logic      read,
	input  logic      write,
	input  logic      memory,
	// slot map from port A
	input  slot_reg_t primary_slot,
	output slot_cs_t  slot_cs
);

	logic [1:0] w_page;
	logic [1:0] w_slot;
	logic       w_mem_access;
	slot_cs_t   ff_slot_cs;

	// ------------------------------------------------------------------------
	// page to slot lookup
	// ------------------------------------------------------------------------

	// 16 KB page from the top two address bits
	assign w_page = address[15:14];

	// field of the page, page n sits at bits 2n+1:2n
	assign w_slot = primary_slot[{w_page, 1'b0} +: 2];

	assign w_mem_access = memory && (read || write);

	// held for as long as the strobe, gone one cycle after it
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_slot_cs <= '0;
		end else if (w_mem_access) begin
			ff_slot_cs <= slot_cs_t'(1) << w_slot;
		end else begin
			ff_slot_cs <= '0;
		end
	end

	assign slot_cs = ff_slot_cs;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// never two slots at once
	a_one_slot: assert property (@(posedge clk) disable iff (!n_reset)
		$onehot0(slot_cs));

endmodule

//--- src/msx_io_top.sv
module msx_io_top
	import msx_io_pkg::*;
(
	input  logic       clk,
	input  logic       n_reset,
	// host bus
	input  io_addr_t   address,
	input  bus_data_t  write_data,
	input  logic       read,
	input  logic       write,
	input  logic       io,
	input  logic       memory,
	output logic       read_ready,
	output bus_data_t  read_data,
	// keyboard controller
	input  logic       key_req,
	input  key_event_t key_event,
	output logic       key_ack,
	// memory slot select
	output slot_cs_t   slot_cs,
	// register pins
	output slot_reg_t  primary_slot,
	output key_row_t   key_row,
	output logic       motor_off,
	output logic       cas_write,
	output logic       caps_led_off,
	output logic       click_sound
);

	slot_reg_t w_primary_slot;
	port_c_t   w_port_c;
	bus_data_t w_key_column;

	// ------------------------------------------------------------------------
	// register block
	// ------------------------------------------------------------------------

	msx_ppi msx_ppi_inst (
		.clk          (clk),
		.n_reset      (n_reset),
		.address      (address),
		.write_data   (write_data),
		.read         (read),
		.write        (write),
		.io           (io),
		.read_ready   (read_ready),
		.read_data    (read_data),
		.key_column   (w_key_column),
		.primary_slot (w_primary_slot),
		.port_c       (w_port_c)
	);

	// keyboard store, row comes from port C
	key_matrix key_matrix_inst (
		.clk        (clk),
		.n_reset    (n_reset),
		.key_req    (key_req),
		.key_event  (key_event),
		.key_ack    (key_ack),
		.key_row    (w_port_c.key_row),
		.key_column (w_key_column)
	);

	// primary slot decode for memory cycles
	slot_select slot_select_inst (
		.clk          (clk),
		.n_reset      (n_reset),
		.address      (address),
		.read         (read),
		.write        (write),
		.memory       (memory),
		.primary_slot (w_primary_slot),
		.slot_cs      (slot_cs)
	);

	// port C fields out to the pins
	assign primary_slot = w_primary_slot;
	assign key_row      = w_port_c.key_row;
	assign motor_off    = w_port_c.motor_off;
	assign cas_write    = w_port_c.cas_write;
	assign caps_led_off = w_port_c.caps_led_off;
	assign click_sound  = w_port_c.click_sound;

endmodule

//--- verification/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic n_reset
);

	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// reset held low for 8 rising edges, released just after the edge
	initial begin
		n_reset = 1'b0;
		repeat (8) @(posedge clk);
		#2 n_reset = 1'b1;
	end

endmodule

//--- verification/tb_msx_io.sv
module tb_msx_io
	import msx_io_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic clk, n_reset, read, write, io, memory, key_req, read_ready, key_ack;
	logic motor_off, cas_write, caps_led_off, click_sound;
	io_addr_t   address;
	bus_data_t  write_data, read_data;
	key_event_t key_event;
	slot_cs_t   slot_cs;
	slot_reg_t  primary_slot;
	key_row_t   key_row;

	// model of the registers and the matrix, 16 rows so 11..15 stay FFh
	slot_reg_t  exp_slot;
	port_c_t    exp_port_c;
	bus_data_t  exp_matrix [16];
	logic       exp_ready;
	logic [1:0] exp_rd_port;
	slot_cs_t   exp_cs;
	bus_data_t  exp_read_data;
	logic [31:0] lfsr;
	int errors, tests_run, tests_bad, test_start;

	tb_clock tb_clock_inst (.clk(clk), .n_reset(n_reset));

	msx_io_top msx_io_top_inst (.*);

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	// I/O ports A8h..AAh answer, ABh and the rest stay silent
	function automatic logic readable(input io_addr_t addr);
		return addr[15:8] == 8'h00 && addr[7:2] == PPI_PORT_BASE && addr[1:0] != PORT_MODE;
	endfunction

	// field of the page picks the slot
	function automatic slot_cs_t slot_onehot(input logic [1:0] page);
		logic [1:0] field;
		field = exp_slot[2 * page +: 2];
		case (field)
			2'd0:    return 4'b0001;
			2'd1:    return 4'b0010;
			2'd2:    return 4'b0100;
			default: return 4'b1000;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			exp_ready <= 1'b0;
			exp_cs    <= '0;
		end else begin
			exp_ready <= io && read && readable(address);
			if (io && read) begin
				exp_rd_port <= address[1:0];
			end
			exp_cs <= (memory && (read || write)) ? slot_onehot(address[15:14]) : '0;
		end
	end

	// bus value expected while ready is up, zero otherwise
	always_comb begin
		exp_read_data = '0;
		if (exp_ready) begin
			case (exp_rd_port)
				PORT_A:  exp_read_data = exp_slot;
				PORT_B:  exp_read_data = exp_matrix[exp_port_c.key_row];
				default: exp_read_data = exp_port_c;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	reset_state: assert property (@(posedge clk) disable iff (!n_reset)
		$rose(n_reset) |-> (!read_ready && !key_ack && slot_cs == '0))
		else begin
			$display("FAIL %0t read_ready key_ack slot_cs got %b %b %b expected 0 0 0000",
				$time, $sampled(read_ready), $sampled(key_ack), $sampled(slot_cs));
			errors++;
		end

	slot_pins: assert property (@(posedge clk) disable iff (!n_reset)
		primary_slot == exp_slot)
		else begin
			$display("FAIL %0t primary_slot got %h expected %h", $time,
				$sampled(primary_slot), $sampled(exp_slot));
			errors++;
		end

	port_c_pins: assert property (@(posedge clk) disable iff (!n_reset)
		{click_sound, caps_led_off, cas_write, motor_off, key_row} == exp_port_c)
		else begin
			$display("FAIL %0t port_c pins got %h expected %h", $time,
				$sampled({click_sound, caps_led_off, cas_write, motor_off, key_row}),
				$sampled(exp_port_c));
			errors++;
		end

	ready_rule: assert property (@(posedge clk) disable iff (!n_reset)
		read_ready == exp_ready)
		else begin
			$display("FAIL %0t read_ready got %b expected %b", $time,
				$sampled(read_ready), $sampled(exp_ready));
			errors++;
		end

	// covers the zero bus outside the ready window too
	read_value: assert property (@(posedge clk) disable iff (!n_reset)
		read_data == exp_read_data)
		else begin
			$display("FAIL %0t read_data got %h expected %h", $time,
				$sampled(read_data), $sampled(exp_read_data));
			errors++;
		end

	ack_rise: assert property (@(posedge clk) disable iff (!n_reset)
		(key_req && !key_ack) |=> key_ack)
		else begin
			$display("FAIL %0t key_ack got 0 expected 1", $time);
			errors++;
		end

	ack_fall: assert property (@(posedge clk) disable iff (!n_reset)
		!key_req |=> !key_ack)
		else begin
			$display("FAIL %0t key_ack got 1 expected 0", $time);
			errors++;
		end

	slot_rule: assert property (@(posedge clk) disable iff (!n_reset)
		slot_cs == exp_cs)
		else begin
			$display("FAIL %0t slot_cs got %b expected %b", $time,
				$sampled(slot_cs), $sampled(exp_cs));
			errors++;
		end

	// ------------------------------------------------------------------------
	// stimulus helpers, each starts and ends 2 ns after a rising edge
	// ------------------------------------------------------------------------

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr  = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	task automatic io_write(input io_addr_t addr, input bus_data_t data);
		address    = addr;
		write_data = data;
		io         = 1'b1;
		write      = 1'b1;
		@(posedge clk);
		#2;
		io    = 1'b0;
		write = 1'b0;
		// register took the value at that edge
		if (addr[15:8] == 8'h00 && addr[7:2] == PPI_PORT_BASE) begin
			if (addr[1:0] == PORT_A) begin
				exp_slot = data;
			end else if (addr[1:0] == PORT_C) begin
				exp_port_c = data;
			end
		end
	endtask

	task automatic io_read(input io_addr_t addr, input logic answered);
		int waited;
		address = addr;
		io      = 1'b1;
		read    = 1'b1;
		waited  = 0;
		if (answered) begin
			while (!read_ready && waited < 20) begin
				@(posedge clk);
				#2;
				waited++;
			end
			if (!read_ready) begin
				$display("timeout waiting for read_ready on port %h", addr);
				errors++;
			end
			// one extra cycle to see ready held
			@(posedge clk);
			#2;
		end else begin
			repeat (3) begin
				@(posedge clk);
				#2;
			end
		end
		io     = 1'b0;
		read   = 1'b0;
		waited = 0;
		while (read_ready && waited < 20) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (read_ready) begin
			$display("timeout waiting for read_ready to drop on port %h", addr);
			errors++;
		end
	endtask

	task automatic mem_access(input io_addr_t addr, input logic is_write, input bus_data_t data);
		address    = addr;
		write_data = data;
		memory     = 1'b1;
		write      = is_write;
		read       = !is_write;
		repeat (2) begin
			@(posedge clk);
			#2;
		end
		memory = 1'b0;
		read   = 1'b0;
		write  = 1'b0;
		@(posedge clk);
		#2;
	endtask

	task automatic key_send(input key_event_t ev);
		int waited;
		key_event = ev;
		key_req   = 1'b1;
		waited    = 0;
		while (!key_ack && waited < 20) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!key_ack) begin
			$display("timeout waiting for key_ack to rise");
			errors++;
		end
		key_req = 1'b0;
		// rows past the last one are dropped by the matrix
		if (ev.row < KEY_ROWS) begin
			exp_matrix[ev.row][ev.column] = !ev.pressed;
		end
		waited = 0;
		while (key_ack && waited < 20) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (key_ack) begin
			$display("timeout waiting for key_ack to fall");
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_start) begin
			tests_bad++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_start);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		test_start = errors;
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		key_event_t ev;
		bus_data_t  other;
		int         waited;
		address    = '0;
		write_data = '0;
		read       = 1'b0;
		write      = 1'b0;
		io         = 1'b0;
		memory     = 1'b0;
		key_req    = 1'b0;
		key_event  = '0;
		lfsr       = 32'h3db;
		errors     = 0;
		tests_run  = 0;
		tests_bad  = 0;
		test_start = 0;
		exp_slot   = SLOT_RESET;
		exp_port_c = PORT_C_RESET;
		for (int r = 0; r < 16; r++) begin
			exp_matrix[r] = 8'hFF;
		end
		waited = 0;
		while (!n_reset && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (!n_reset) begin
			$display("timeout waiting for reset release");
			errors++;
		end
		#2;

		// reset values, port C reads 7Fh
		io_read(16'h00AA, 1'b1);
		io_read(16'h00A8, 1'b1);
		finish_test("reset state");

		for (int i = 0; i < 8; i++) begin
			io_write(16'h00A8, bus_data_t'(lfsr_bits(8)));
			io_read(16'h00A8, 1'b1);
			io_write(16'h00AA, bus_data_t'(lfsr_bits(8)));
			io_read(16'h00AA, 1'b1);
		end
		finish_test("register write and readback");

		for (int i = 0; i < 24; i++) begin
			ev.pressed = lfsr_bits(1) != 0;
			ev.row     = key_row_t'(lfsr_bits(4));
			ev.column  = key_col_t'(lfsr_bits(3));
			key_send(ev);
		end
		// walk every row, upper port C bits random
		for (int r = 0; r < 16; r++) begin
			io_write(16'h00AA, {4'(lfsr_bits(4)), key_row_t'(r)});
			io_read(16'h00A9, 1'b1);
		end
		finish_test("keyboard");

		for (int i = 0; i < 4; i++) begin
			io_write(16'h00A8, bus_data_t'(lfsr_bits(8)));
			for (int p = 0; p < 4; p++) begin
				mem_access({2'(p), 14'(lfsr_bits(14))}, 1'b0, '0);
				mem_access({2'(p), 14'(lfsr_bits(14))}, 1'b1, bus_data_t'(lfsr_bits(8)));
			end
			// an I/O cycle must leave slot_cs low
			io_read(16'h00A9, 1'b1);
		end
		finish_test("slot select");

		io_write(16'h00AB, bus_data_t'(lfsr_bits(8)));
		other = bus_data_t'(lfsr_bits(8));
		if (other[7:2] == PPI_PORT_BASE) begin
			other = other ^ 8'h40;
		end
		io_write({8'h00, other}, bus_data_t'(lfsr_bits(8)));
		io_read(16'h00AB, 1'b0);
		io_read({8'h00, other}, 1'b0);
		// memory cycles on PPI addresses
		mem_access(16'h00A8, 1'b1, bus_data_t'(lfsr_bits(8)));
		mem_access(16'h00AA, 1'b1, bus_data_t'(lfsr_bits(8)));
		mem_access(16'h00A9, 1'b0, '0);
		io_read(16'h00A8, 1'b1);
		io_read(16'h00AA, 1'b1);
		finish_test("ignored accesses");

		repeat (2) @(posedge clk);
		#2;
		$display("summary: %0d tests, %0d ok, %0d bad, %0d errors",
			tests_run, tests_run - tests_bad, tests_bad, errors);
		if (errors == 0 && tests_bad == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- files.f
common/msx_io_pkg.sv
ppi/msx_ppi.sv
keyboard/key_matrix.sv
src/slot_select.sv
src/msx_io_top.sv
verification/tb_clock.sv
verification/tb_msx_io.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_msx_io
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = tests failed
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
